//--- verilog/rv_arch_pkg.sv
// rv64 architectural constants and register index types

package rv_arch_pkg;

  // default data width, overridden by the top-level parameter
  localparam int XLEN_DEFAULT = 64;

  // fixed by the integer ISA
  localparam int NUM_REGS = 32;
  localparam int REG_IDX_W = $clog2(NUM_REGS);

  // immediate field as it sits in an I-type instruction
  localparam int IMM_W = 12;

  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [IMM_W-1:0]     imm_t;

  // x0, hardwired to zero
  localparam reg_idx_t REG_ZERO = '0;

endpackage

//--- verilog/rv_exec_pkg.sv
// execute unit opcodes, controller states and the command format

package rv_exec_pkg;

  // integer alu operations
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_e;

  // controller FSM
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    READ    = 2'd1,
    DONE    = 2'd2,
    RELEASE = 2'd3
  } exec_state_e;

  // one alu command, register-register or register-immediate
  typedef struct packed {
    alu_op_e               op;
    rv_arch_pkg::reg_idx_t rd;
    rv_arch_pkg::reg_idx_t rs1;
    rv_arch_pkg::reg_idx_t rs2;
    rv_arch_pkg::imm_t     imm;
    // take sign-extended imm in place of rs2
    logic                  use_imm;
  } exec_cmd_t;

endpackage

//--- verilog/regfile.sv
// 32-entry integer register file, x0 reads zero, two read ports and one write port

`timescale 1ns/100ps

module regfile #(
  parameter int XLEN = rv_arch_pkg::XLEN_DEFAULT
) (
  input  logic                  clk,
  input  logic                  rst,

  input  rv_arch_pkg::reg_idx_t i_rs1,
  input  logic                  i_rs1_ren,
  input  rv_arch_pkg::reg_idx_t i_rs2,
  input  logic                  i_rs2_ren,

  input  rv_arch_pkg::reg_idx_t i_rd,
  input  logic                  i_rd_wen,
  input  logic [XLEN-1:0]       i_rd_data,

  output logic [XLEN-1:0]       o_rs1_data,
  output logic [XLEN-1:0]       o_rs2_data
);

  import rv_arch_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS];

  // write port, x0 never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen && (i_rd != REG_ZERO)) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  // read port 1
  always_comb begin
    if (i_rs1_ren && (i_rs1 != REG_ZERO)) begin
      o_rs1_data = regs[i_rs1];
    end else begin
      o_rs1_data = '0;
    end
  end

  // read port 2
  always_comb begin
    if (i_rs2_ren && (i_rs2 != REG_ZERO)) begin
      o_rs2_data = regs[i_rs2];
    end else begin
      o_rs2_data = '0;
    end
  end

endmodule

//--- verilog/alu.sv
// combinational integer ALU for add, sub, logic, shift and set-less-than ops

`timescale 1ns/100ps

module alu #(
  parameter int XLEN = rv_arch_pkg::XLEN_DEFAULT
) (
  input  rv_exec_pkg::alu_op_e i_op,
  input  logic [XLEN-1:0]      i_a,
  input  logic [XLEN-1:0]      i_b,
  output logic [XLEN-1:0]      o_y
);

  import rv_exec_pkg::*;

  localparam int SHAMT_W = $clog2(XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;

  // only the low bits of b count for shifts
  assign shamt = i_b[SHAMT_W-1:0];

  assign lt_signed   = $signed(i_a) < $signed(i_b);
  assign lt_unsigned = i_a < i_b;

  always_comb begin
    case (i_op)
      ALU_ADD: begin
        o_y = i_a + i_b;
      end
      ALU_SUB: begin
        o_y = i_a - i_b;
      end
      ALU_AND: begin
        o_y = i_a & i_b;
      end
      ALU_OR: begin
        o_y = i_a | i_b;
      end
      ALU_XOR: begin
        o_y = i_a ^ i_b;
      end
      ALU_SLL: begin
        o_y = i_a << shamt;
      end
      ALU_SRL: begin
        o_y = i_a >> shamt;
      end
      ALU_SRA: begin
        o_y = $unsigned($signed(i_a) >>> shamt);
      end
      ALU_SLT: begin
        o_y = {{(XLEN-1){1'b0}}, lt_signed};
      end
      ALU_SLTU: begin
        o_y = {{(XLEN-1){1'b0}}, lt_unsigned};
      end
      default: begin
        // unused encodings
        o_y = '0;
      end
    endcase
  end

endmodule

//--- verilog/exec_ctrl.sv
// execute controller with a four-phase req/ack FSM that reads operands and writes rd

`timescale 1ns/100ps

module exec_ctrl #(
  parameter int XLEN = rv_arch_pkg::XLEN_DEFAULT
) (
  input  logic                   clk,
  input  logic                   rst,

  // command handshake
  input  logic                   i_req,
  input  rv_exec_pkg::exec_cmd_t i_cmd,
  output logic                   o_ack,
  output logic [XLEN-1:0]        o_rsp_data,

  // regfile read side
  output rv_arch_pkg::reg_idx_t  o_rs1,
  output logic                   o_rs1_ren,
  output rv_arch_pkg::reg_idx_t  o_rs2,
  output logic                   o_rs2_ren,
  input  logic [XLEN-1:0]        i_rs1_data,
  input  logic [XLEN-1:0]        i_rs2_data,

  // regfile write side
  output rv_arch_pkg::reg_idx_t  o_rd,
  output logic                   o_rd_wen,
  output logic [XLEN-1:0]        o_rd_data,

  // alu
  output rv_exec_pkg::alu_op_e   o_alu_op,
  output logic [XLEN-1:0]        o_alu_a,
  output logic [XLEN-1:0]        o_alu_b,
  input  logic [XLEN-1:0]        i_alu_y
);

  import rv_arch_pkg::*;
  import rv_exec_pkg::*;

  exec_state_e     state;
  exec_state_e     state_nxt;
  exec_cmd_t       cmd_q;
  logic [XLEN-1:0] imm_sext;
  logic            in_read;

  assign in_read = (state == READ);

  // next state
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (i_req) begin
          state_nxt = READ;
        end
      end
      READ: begin
        state_nxt = DONE;
      end
      DONE: begin
        // hold ack until the requester lets go
        if (!i_req) begin
          state_nxt = RELEASE;
        end
      end
      RELEASE: begin
        state_nxt = IDLE;
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // command latch
  always_ff @(posedge clk) begin
    if ((state == IDLE) && i_req) begin
      cmd_q <= i_cmd;
    end
  end

  // ack and response
  always_ff @(posedge clk) begin
    if (rst) begin
      o_ack      <= 1'b0;
      o_rsp_data <= '0;
    end else if (in_read) begin
      o_ack      <= 1'b1;
      o_rsp_data <= i_alu_y;
    end else if ((state == DONE) && !i_req) begin
      o_ack <= 1'b0;
    end
  end

  assign imm_sext = {{(XLEN-IMM_W){cmd_q.imm[IMM_W-1]}}, cmd_q.imm};

  // operand reads only in READ
  assign o_rs1     = cmd_q.rs1;
  assign o_rs1_ren = in_read;
  assign o_rs2     = cmd_q.rs2;
  assign o_rs2_ren = in_read && !cmd_q.use_imm;

  assign o_alu_op = cmd_q.op;
  assign o_alu_a  = i_rs1_data;
  assign o_alu_b  = cmd_q.use_imm ? imm_sext : i_rs2_data;

  // one-cycle write with x0 filtered in the regfile
  assign o_rd      = cmd_q.rd;
  assign o_rd_wen  = in_read;
  assign o_rd_data = i_alu_y;

endmodule

//--- verilog/exec_core.sv
// execute core top, controller plus register file plus ALU

`timescale 1ns/100ps

module exec_core #(
  parameter int XLEN = rv_arch_pkg::XLEN_DEFAULT
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_req,
  input  rv_exec_pkg::exec_cmd_t i_cmd,
  output logic                   o_ack,
  output logic [XLEN-1:0]        o_rsp_data
);

  import rv_arch_pkg::*;
  import rv_exec_pkg::*;

  reg_idx_t        rs1;
  reg_idx_t        rs2;
  reg_idx_t        rd;
  logic            rs1_ren;
  logic            rs2_ren;
  logic            rd_wen;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] rd_data;
  alu_op_e         alu_op;
  logic [XLEN-1:0] alu_a;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_y;

  exec_ctrl #(.XLEN(XLEN)) exec_ctrl_inst (
    .clk        (clk),
    .rst        (rst),
    .i_req      (i_req),
    .i_cmd      (i_cmd),
    .o_ack      (o_ack),
    .o_rsp_data (o_rsp_data),
    .o_rs1      (rs1),
    .o_rs1_ren  (rs1_ren),
    .o_rs2      (rs2),
    .o_rs2_ren  (rs2_ren),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_rd       (rd),
    .o_rd_wen   (rd_wen),
    .o_rd_data  (rd_data),
    .o_alu_op   (alu_op),
    .o_alu_a    (alu_a),
    .o_alu_b    (alu_b),
    .i_alu_y    (alu_y)
  );

  regfile #(.XLEN(XLEN)) regfile_inst (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (rs1),
    .i_rs1_ren  (rs1_ren),
    .i_rs2      (rs2),
    .i_rs2_ren  (rs2_ren),
    .i_rd       (rd),
    .i_rd_wen   (rd_wen),
    .i_rd_data  (rd_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  alu #(.XLEN(XLEN)) alu_inst (
    .i_op (alu_op),
    .i_a  (alu_a),
    .i_b  (alu_b),
    .o_y  (alu_y)
  );

endmodule

//--- verification/exec_core_properties.sv
// handshake protocol checks for the execute core, bound into every exec_core

`timescale 1ns/100ps

module exec_core_properties #(
  parameter int XLEN = rv_arch_pkg::XLEN_DEFAULT
) (
  input logic            clk,
  input logic            rst,
  input logic            i_req,
  input logic            o_ack,
  input logic [XLEN-1:0] o_rsp_data
);

  // failed property count
  int fail_count = 0;

  ack_low_after_reset: assert property (@(posedge clk) rst |=> !o_ack)
    else begin
      $error("o_ack high in the cycle after reset");
      fail_count++;
    end

  ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(o_ack) |-> $past(i_req))
    else begin
      $error("o_ack rose with no request pending");
      fail_count++;
    end

  // back-pressure, ack held until the requester lets go
  ack_held_during_req: assert property (@(posedge clk) disable iff (rst)
    o_ack && i_req |=> o_ack)
    else begin
      $error("o_ack dropped while i_req still high");
      fail_count++;
    end

  rsp_stable_during_ack: assert property (@(posedge clk) disable iff (rst)
    o_ack && $past(o_ack) |-> $stable(o_rsp_data))
    else begin
      $error("o_rsp_data changed while o_ack high");
      fail_count++;
    end

  ack_latency_two: assert property (@(posedge clk) disable iff (rst)
    $past(i_req, 2) && !$past(i_req, 3) |-> $rose(o_ack))
    else begin
      $error("o_ack did not rise two cycles after the request");
      fail_count++;
    end

  ack_only_at_latency_two: assert property (@(posedge clk) disable iff (rst)
    $rose(o_ack) |-> $past(i_req, 2) && !$past(i_req, 3))
    else begin
      $error("o_ack rose at the wrong distance from the request");
      fail_count++;
    end

endmodule

bind exec_core exec_core_properties #(.XLEN(XLEN)) exec_core_props_inst (
  .clk        (clk),
  .rst        (rst),
  .i_req      (i_req),
  .o_ack      (o_ack),
  .o_rsp_data (o_rsp_data)
);

//--- verification/exec_core_tb.sv
// testbench for the execute core checking random alu commands against a shadow register model

`timescale 1ns/100ps

module exec_core_tb;

  import rv_arch_pkg::*;
  import rv_exec_pkg::*;

  localparam int XLEN           = 64;
  localparam int MAX_HOLD       = 7;
  localparam int CYCLES_PER_CMD = 4;
  localparam int N_RESET        = NUM_REGS;
  localparam int N_MIX          = 16;
  localparam int N_PER_OP       = 3;
  localparam int N_ALU          = (NUM_REGS - 1) + N_MIX + 10 * N_PER_OP;
  localparam int N_IMM          = 20;
  localparam int N_CHAIN        = 12;
  localparam int N_ZERO         = 7;
  localparam int N_BP           = 20;
  localparam int N_TOTAL        = N_RESET + N_ALU + N_IMM + N_CHAIN + N_ZERO + N_BP;
  localparam int TIMEOUT_CYCLES = N_TOTAL * (CYCLES_PER_CMD + MAX_HOLD) + 200;

  logic            clk;
  logic            rst;
  logic            i_req;
  exec_cmd_t       i_cmd;
  logic            o_ack;
  logic [XLEN-1:0] o_rsp_data;

  logic [31:0]     lfsr;
  logic [XLEN-1:0] shadow [NUM_REGS];
  int              pass_cnt;
  int              fail_cnt;
  int              test_pass0;
  int              test_fail0;
  int              cycles;

  exec_core #(.XLEN(XLEN)) exec_core_inst (
    .clk        (clk),
    .rst        (rst),
    .i_req      (i_req),
    .i_cmd      (i_cmd),
    .o_ack      (o_ack),
    .o_rsp_data (o_rsp_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // lfsr polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic reg_idx_t rand_reg();
    logic [63:0] v;
    v = rand_bits(REG_IDX_W);
    return v[REG_IDX_W-1:0];
  endfunction

  function automatic imm_t rand_imm();
    logic [63:0] v;
    v = rand_bits(IMM_W);
    return v[IMM_W-1:0];
  endfunction

  function automatic alu_op_e rand_op();
    logic [63:0] v;
    v = rand_bits(4) % 64'd10;
    return alu_op_e'(v[3:0]);
  endfunction

  function automatic exec_cmd_t build_cmd(input alu_op_e op, input reg_idx_t rd,
                                          input reg_idx_t rs1, input reg_idx_t rs2,
                                          input imm_t imm, input logic use_imm);
    return '{op, rd, rs1, rs2, imm, use_imm};
  endfunction

  // rv64 integer semantics
  function automatic logic [XLEN-1:0] model_alu(input alu_op_e op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic [5:0]        sh;
    logic [2*XLEN-1:0] ext;
    logic              lt_u;
    logic              lt_s;
    sh   = b[5:0];
    ext  = {{XLEN{a[XLEN-1]}}, a} >> sh;
    lt_u = a < b;
    // differing signs decide on their own
    lt_s = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : lt_u;
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return ext[XLEN-1:0];
      ALU_SLT:  return {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: return {{(XLEN-1){1'b0}}, lt_u};
      default:  return '0;
    endcase
  endfunction

  task automatic wait_ack(input logic level);
    do begin
      @(posedge clk);
      #1;
    end while (o_ack != level);
  endtask

  // one full four-phase transfer with i_req held hold extra cycles after the ack
  task automatic issue(input exec_cmd_t cmd, input int hold);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] expect_y;
    alu_op_e         op;
    op = cmd.op;
    a  = shadow[cmd.rs1];
    if (cmd.use_imm) begin
      b = {{(XLEN - IMM_W){cmd.imm[IMM_W-1]}}, cmd.imm};
    end else begin
      b = shadow[cmd.rs2];
    end
    expect_y = model_alu(op, a, b);
    i_cmd = cmd;
    i_req = 1'b1;
    wait_ack(1'b1);
    assert (o_rsp_data == expect_y) begin
      pass_cnt++;
    end else begin
      $display("ERR %0t: %s rd x%0d rs1 x%0d rs2 x%0d use_imm %0b imm %h got %h expected %h",
               $time, op.name(), cmd.rd, cmd.rs1, cmd.rs2, cmd.use_imm, cmd.imm,
               o_rsp_data, expect_y);
      fail_cnt++;
    end
    if (cmd.rd != REG_ZERO) begin
      shadow[cmd.rd] = expect_y;
    end
    repeat (hold) begin
      @(posedge clk);
      #1;
    end
    i_req = 1'b0;
    wait_ack(1'b0);
    // one idle cycle before the next request
    @(posedge clk);
    #1;
  endtask

  task automatic start_test();
    test_pass0 = pass_cnt;
    test_fail0 = fail_cnt;
  endtask

  task automatic finish_test(input string name);
    $display("test %-16s checks %0d errors %0d", name,
             (pass_cnt - test_pass0) + (fail_cnt - test_fail0), fail_cnt - test_fail0);
  endtask

  task automatic test_reset_clear();
    start_test();
    for (int r = 0; r < N_RESET; r++) begin
      issue(build_cmd(ALU_ADD, REG_ZERO, reg_idx_t'(r), REG_ZERO, '0, 1'b1), 0);
    end
    finish_test("reset_clear");
  endtask

  task automatic test_alu_ops();
    alu_op_e op;
    start_test();
    for (int r = 1; r < NUM_REGS; r++) begin
      issue(build_cmd(ALU_ADD, reg_idx_t'(r), REG_ZERO, REG_ZERO, rand_imm(), 1'b1), 0);
    end
    // spread the values over all 64 bits
    for (int k = 0; k < N_MIX; k++) begin
      if (k % 2 == 0) begin
        op = ALU_SLL;
      end else begin
        op = ALU_XOR;
      end
      issue(build_cmd(op, rand_reg(), rand_reg(), rand_reg(), '0, 1'b0), 0);
    end
    for (int k = 0; k < 10; k++) begin
      op = alu_op_e'(4'(k));
      for (int j = 0; j < N_PER_OP; j++) begin
        issue(build_cmd(op, rand_reg(), rand_reg(), rand_reg(), '0, 1'b0), 0);
      end
    end
    finish_test("alu_ops");
  endtask

  task automatic test_imm_operand();
    imm_t imm;
    start_test();
    for (int k = 0; k < N_IMM; k++) begin
      imm = rand_imm();
      imm[IMM_W-1] = 1'b1;
      issue(build_cmd(rand_op(), rand_reg(), rand_reg(), REG_ZERO, imm, 1'b1), 0);
    end
    finish_test("imm_operand");
  endtask

  task automatic test_write_readback();
    imm_t imm;
    start_test();
    imm = rand_imm() | 12'h001;
    issue(build_cmd(ALU_ADD, 5'd5, REG_ZERO, REG_ZERO, imm, 1'b1), 0);
    // each add doubles x5 and depends on the previous write
    for (int k = 0; k < N_CHAIN - 2; k++) begin
      issue(build_cmd(ALU_ADD, 5'd5, 5'd5, 5'd5, '0, 1'b0), 0);
    end
    issue(build_cmd(ALU_SUB, 5'd6, 5'd5, REG_ZERO, 12'd1, 1'b1), 0);
    finish_test("write_readback");
  endtask

  task automatic test_zero_reg();
    start_test();
    for (int k = 0; k < N_ZERO - 3; k++) begin
      issue(build_cmd(rand_op(), REG_ZERO, rand_reg(), rand_reg(), '0, 1'b0), 0);
    end
    // last write aimed at x0 carries a nonzero value
    issue(build_cmd(ALU_ADD, REG_ZERO, REG_ZERO, REG_ZERO, 12'h5a5, 1'b1), 0);
    issue(build_cmd(ALU_ADD, 5'd7, REG_ZERO, REG_ZERO, '0, 1'b1), 0);
    issue(build_cmd(ALU_OR, 5'd8, REG_ZERO, REG_ZERO, '0, 1'b0), 0);
    finish_test("zero_reg");
  endtask

  task automatic test_backpressure();
    exec_cmd_t   cmd;
    logic [63:0] sel;
    int          hold;
    start_test();
    for (int k = 0; k < N_BP; k++) begin
      cmd.op      = rand_op();
      cmd.rd      = rand_reg();
      cmd.rs1     = rand_reg();
      cmd.rs2     = rand_reg();
      cmd.imm     = rand_imm();
      sel         = rand_bits(1);
      cmd.use_imm = sel[0];
      hold        = int'(rand_bits(3));
      issue(cmd, hold);
    end
    finish_test("backpressure");
  endtask

  // watchdog
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("run timed out after %0d cycles with the handshake stuck", cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    int prop_fails;
    rst      = 1'b1;
    i_req    = 1'b0;
    i_cmd    = '0;
    lfsr     = 32'h1d6fddfc;
    pass_cnt = 0;
    fail_cnt = 0;
    for (int r = 0; r < NUM_REGS; r++) begin
      shadow[r] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    test_reset_clear();
    test_alu_ops();
    test_imm_operand();
    test_write_readback();
    test_zero_reg();
    test_backpressure();
    prop_fails = exec_core_inst.exec_core_props_inst.fail_count;
    $display("checks passed %0d failed %0d, property failures %0d",
             pass_cnt, fail_cnt, prop_fails);
    if ((fail_cnt == 0) && (prop_fails == 0)) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
verilog/rv_arch_pkg.sv
verilog/rv_exec_pkg.sv
verilog/regfile.sv
verilog/alu.sv
verilog/exec_ctrl.sv
verilog/exec_core.sv
verification/exec_core_properties.sv
verification/exec_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module exec_core_tb \
  -Mdir obj_dir \
  -f flist.f

sim_out="$(./obj_dir/Vexec_core_tb +verilator+error+limit+100 2>&1)" || true
echo "$sim_out"

if grep -q "SIMULATION PASSED" <<< "$sim_out"; then
  echo "run.sh: pass"
  exit 0
fi

echo "run.sh: fail"
exit 1
